//--- Bender.yml
package:
  name: soc_top

sources:
  # packages first, then the RTL
  - files:
      - hdl/axi_pkg.sv
      - hdl/soc_map_pkg.sv
      - hdl/axi_xbar.sv
      - hdl/rtc_slave.sv
      - hdl/sram_slave.sv
      - hdl/soc_top.sv

  - target: test
    files:
      - bench/tb_soc_top.sv

//--- bench/tb_soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_top;

	localparam int CLK_NS = 8;
	localparam int RST_CYCLES = 16;
	localparam logic [31:0] SEED = 32'h624f_d5eb;
	// beats moved per test, writes and reads together
	localparam int BEATS_SUM = 11 + 36 + 8 + 3 + 3 + 4;
	localparam int WATCHDOG_CYCLES = BEATS_SUM * 20 + RST_CYCLES;
	localparam logic [31:0] HOLE_ADDR = 32'h4000_0000;

	logic clk;
	logic rst;
	logic [axi_pkg::ADDR_W-1:0] araddr;
	logic arvalid;
	logic [axi_pkg::SIZE_W-1:0] arsize;
	logic [axi_pkg::LEN_W-1:0] arlen;
	logic [axi_pkg::BURST_W-1:0] arburst;
	logic arready;
	logic [axi_pkg::DATA_W-1:0] rdata;
	logic [axi_pkg::RESP_W-1:0] rresp;
	logic rvalid;
	logic rlast;
	logic rready;
	logic [axi_pkg::ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axi_pkg::DATA_W-1:0] wdata;
	logic [axi_pkg::STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [axi_pkg::RESP_W-1:0] bresp;
	logic bvalid;
	logic bready;

	// what the SRAM should hold, only written words are ever read
	logic [axi_pkg::DATA_W-1:0] ref_mem [soc_map_pkg::SRAM_WORDS];
	logic [axi_pkg::DATA_W-1:0] rd_data_q [$];
	logic [axi_pkg::RESP_W-1:0] rd_resp_q [$];
	logic rd_last_q [$];
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	soc_top u_soc_top (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arsize(arsize), .arlen(arlen),
		.arburst(arburst), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rlast(rlast), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic check_data(input string name, input logic [axi_pkg::DATA_W-1:0] got,
			input logic [axi_pkg::DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_resp(input string name, input logic [axi_pkg::RESP_W-1:0] got,
			input logic [axi_pkg::RESP_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_last(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	function automatic logic [axi_pkg::DATA_W-1:0] merge_bytes(
			input logic [axi_pkg::DATA_W-1:0] old_word,
			input logic [axi_pkg::DATA_W-1:0] new_word,
			input logic [axi_pkg::STRB_W-1:0] strb);
		logic [axi_pkg::DATA_W-1:0] res;
		res = old_word;
		for (int i = 0; i < axi_pkg::STRB_W; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return res;
	endfunction

	// inputs change on the falling edge, outputs are sampled 1 ns later
	task automatic write_word(input logic [axi_pkg::ADDR_W-1:0] addr,
			input logic [axi_pkg::DATA_W-1:0] data, input logic [axi_pkg::STRB_W-1:0] strb,
			output logic [axi_pkg::RESP_W-1:0] resp);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		#1;
		while (!(awready && wready)) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		#1;
		while (!bvalid) begin
			@(negedge clk);
			#1;
		end
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic sram_write(input int idx, input logic [axi_pkg::DATA_W-1:0] data,
			input logic [axi_pkg::STRB_W-1:0] strb);
		logic [axi_pkg::RESP_W-1:0] resp;
		write_word(soc_map_pkg::SRAM_BASE + (idx << 2), data, strb, resp);
		check_resp("bresp", resp, axi_pkg::RESP_OKAY);
		ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
	endtask

	// collects every beat, checks that a stalled beat holds still
	task automatic read_burst(input logic [axi_pkg::ADDR_W-1:0] addr,
			input logic [axi_pkg::LEN_W-1:0] len, input logic [axi_pkg::BURST_W-1:0] burst,
			input logic stall);
		logic hold;
		logic hold_last;
		logic [axi_pkg::DATA_W-1:0] hold_data;
		logic done;
		rd_data_q.delete();
		rd_resp_q.delete();
		rd_last_q.delete();
		@(negedge clk);
		araddr = addr;
		arlen = len;
		arburst = burst;
		arsize = axi_pkg::SIZE_WORD;
		arvalid = 1'b1;
		#1;
		while (!arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		arvalid = 1'b0;
		hold = 1'b0;
		done = 1'b0;
		while (!done) begin
			rready = stall ? (($urandom % 4) != 0) : 1'b1;
			#1;
			if (hold) begin
				check_last("rvalid", rvalid, 1'b1);
				check_data("rdata", rdata, hold_data);
				check_last("rlast", rlast, hold_last);
			end
			hold = rvalid && !rready;
			hold_data = rdata;
			hold_last = rlast;
			if (rvalid && rready) begin
				rd_data_q.push_back(rdata);
				rd_resp_q.push_back(rresp);
				rd_last_q.push_back(rlast);
				done = rlast;
			end
			@(negedge clk);
		end
		rready = 1'b0;
	endtask

	// error bursts carry zero data
	task automatic expect_burst(input int idx, input int len,
			input logic [axi_pkg::BURST_W-1:0] burst, input logic [axi_pkg::RESP_W-1:0] resp);
		int word;
		if (rd_data_q.size() != len + 1) begin
			$display("read returned %0d beats instead of %0d", rd_data_q.size(), len + 1);
			test_errors++;
		end
		for (int i = 0; i < rd_data_q.size(); i++) begin
			word = (burst == axi_pkg::BURST_INCR) ? idx + i : idx;
			if (resp == axi_pkg::RESP_OKAY) begin
				check_data("rdata", rd_data_q[i], ref_mem[word]);
			end else begin
				check_data("rdata", rd_data_q[i], '0);
			end
			check_resp("rresp", rd_resp_q[i], resp);
			check_last("rlast", rd_last_q[i], i == len);
		end
	endtask

	task automatic rtc_read(input logic [31:0] ofs, output logic [axi_pkg::DATA_W-1:0] data);
		read_burst(soc_map_pkg::RTC_BASE + ofs, 8'd0, axi_pkg::BURST_INCR, 1'b0);
		if (rd_data_q.size() != 1) begin
			$display("clock read returned %0d beats instead of one", rd_data_q.size());
			test_errors++;
		end
		check_resp("rresp", rd_resp_q[0], axi_pkg::RESP_OKAY);
		check_last("rlast", rd_last_q[0], 1'b1);
		data = rd_data_q[0];
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%-20s ok", name);
		end else begin
			$display("%-20s %0d errors", name, test_errors);
			tests_failed++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	task automatic test_strobed_writes();
		check_last("arready", arready, 1'b0);
		check_last("rvalid", rvalid, 1'b0);
		check_last("awready", awready, 1'b0);
		check_last("wready", wready, 1'b0);
		check_last("bvalid", bvalid, 1'b0);
		for (int i = 0; i < 4; i++) begin
			sram_write(i, $urandom, 4'hf);
		end
		sram_write(1, $urandom, 4'b0101);
		sram_write(2, $urandom, 4'b1000);
		sram_write(3, $urandom, 4'b0000);
		for (int i = 0; i < 4; i++) begin
			read_burst(soc_map_pkg::SRAM_BASE + (i << 2), 8'd0, axi_pkg::BURST_INCR, 1'b0);
			expect_burst(i, 0, axi_pkg::BURST_INCR, axi_pkg::RESP_OKAY);
		end
		close_test("strobed_writes");
	endtask

	task automatic test_incr_bursts();
		for (int i = 16; i < 32; i++) begin
			sram_write(i, $urandom, 4'hf);
		end
		read_burst(soc_map_pkg::SRAM_BASE + (16 << 2), 8'd3, axi_pkg::BURST_INCR, 1'b1);
		expect_burst(16, 3, axi_pkg::BURST_INCR, axi_pkg::RESP_OKAY);
		read_burst(soc_map_pkg::SRAM_BASE + (16 << 2), 8'd15, axi_pkg::BURST_INCR, 1'b1);
		expect_burst(16, 15, axi_pkg::BURST_INCR, axi_pkg::RESP_OKAY);
		close_test("incr_bursts");
	endtask

	task automatic test_fixed_wrap();
		read_burst(soc_map_pkg::SRAM_BASE + (20 << 2), 8'd3, axi_pkg::BURST_FIXED, 1'b1);
		expect_burst(20, 3, axi_pkg::BURST_FIXED, axi_pkg::RESP_OKAY);
		read_burst(soc_map_pkg::SRAM_BASE + (16 << 2), 8'd3, axi_pkg::BURST_WRAP, 1'b1);
		expect_burst(16, 3, axi_pkg::BURST_WRAP, axi_pkg::RESP_SLVERR);
		close_test("fixed_wrap");
	endtask

	task automatic test_rtc_reads();
		logic [axi_pkg::DATA_W-1:0] lo_first;
		logic [axi_pkg::DATA_W-1:0] lo_second;
		logic [axi_pkg::DATA_W-1:0] hi;
		rtc_read(soc_map_pkg::RTC_LO_OFS, lo_first);
		rtc_read(soc_map_pkg::RTC_LO_OFS, lo_second);
		if (!(lo_second > lo_first)) begin
			$display("clock did not advance between reads: %h then %h", lo_first, lo_second);
			test_errors++;
		end
		rtc_read(soc_map_pkg::RTC_HI_OFS, hi);
		check_data("rdata", hi, '0);
		close_test("rtc_reads");
	endtask

	task automatic test_rtc_write();
		logic [axi_pkg::RESP_W-1:0] resp;
		logic [axi_pkg::DATA_W-1:0] lo;
		write_word(soc_map_pkg::RTC_BASE, 32'hdead_beef, 4'hf, resp);
		check_resp("bresp", resp, axi_pkg::RESP_SLVERR);
		read_burst(soc_map_pkg::SRAM_BASE, 8'd0, axi_pkg::BURST_INCR, 1'b0);
		expect_burst(0, 0, axi_pkg::BURST_INCR, axi_pkg::RESP_OKAY);
		rtc_read(soc_map_pkg::RTC_LO_OFS, lo);
		close_test("rtc_write");
	endtask

	task automatic test_unmapped();
		logic [axi_pkg::RESP_W-1:0] resp;
		read_burst(HOLE_ADDR, 8'd2, axi_pkg::BURST_INCR, 1'b0);
		expect_burst(0, 2, axi_pkg::BURST_INCR, axi_pkg::RESP_DECERR);
		write_word(HOLE_ADDR, 32'h1234_5678, 4'hf, resp);
		check_resp("bresp", resp, axi_pkg::RESP_DECERR);
		close_test("unmapped");
	endtask

	initial begin
		int seed_val;
		seed_val = $urandom(SEED);
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		clk = 1'b0;
		rst = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		arsize = '0;
		arlen = '0;
		arburst = '0;
		rready = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_strobed_writes();
		test_incr_bursts();
		test_fixed_wrap();
		test_rtc_reads();
		test_rtc_write();
		test_unmapped();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
hdl/axi_pkg.sv
hdl/soc_map_pkg.sv
hdl/axi_xbar.sv
hdl/rtc_slave.sv
hdl/sram_slave.sv
hdl/soc_top.sv
bench/tb_soc_top.sv

//--- hdl/axi_pkg.sv
`default_nettype none

package axi_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int LEN_W = 8;
	localparam int SIZE_W = 3;
	localparam int BURST_W = 2;
	localparam int RESP_W = 2;

	// widest beat the data bus carries, log2 of bytes
	localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;

	// response codes
	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
	localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

	// burst codes
	localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
	localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;
	localparam logic [BURST_W-1:0] BURST_WRAP = 2'b10;

endpackage

`default_nettype wire

//--- hdl/axi_xbar.sv
`timescale 1ns/1ns
`default_nettype none

module axi_xbar (
	input  logic clk,
	input  logic rst,
	// master read
	input  logic [axi_pkg::ADDR_W-1:0] araddr,
	input  logic arvalid,
	input  logic [axi_pkg::SIZE_W-1:0] arsize,
	input  logic [axi_pkg::LEN_W-1:0] arlen,
	input  logic [axi_pkg::BURST_W-1:0] arburst,
	output logic arready,
	output logic [axi_pkg::DATA_W-1:0] rdata,
	output logic [axi_pkg::RESP_W-1:0] rresp,
	output logic rvalid,
	output logic rlast,
	input  logic rready,
	// master write
	input  logic [axi_pkg::ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [axi_pkg::DATA_W-1:0] wdata,
	input  logic [axi_pkg::STRB_W-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [axi_pkg::RESP_W-1:0] bresp,
	output logic bvalid,
	input  logic bready,
	// sram side
	output logic [axi_pkg::ADDR_W-1:0] sram_araddr,
	output logic sram_arvalid,
	output logic [axi_pkg::SIZE_W-1:0] sram_arsize,
	output logic [axi_pkg::LEN_W-1:0] sram_arlen,
	output logic [axi_pkg::BURST_W-1:0] sram_arburst,
	input  logic sram_arready,
	input  logic [axi_pkg::DATA_W-1:0] sram_rdata,
	input  logic [axi_pkg::RESP_W-1:0] sram_rresp,
	input  logic sram_rvalid,
	input  logic sram_rlast,
	output logic sram_rready,
	output logic [axi_pkg::ADDR_W-1:0] sram_awaddr,
	output logic sram_awvalid,
	input  logic sram_awready,
	output logic [axi_pkg::DATA_W-1:0] sram_wdata,
	output logic [axi_pkg::STRB_W-1:0] sram_wstrb,
	output logic sram_wvalid,
	input  logic sram_wready,
	input  logic [axi_pkg::RESP_W-1:0] sram_bresp,
	input  logic sram_bvalid,
	output logic sram_bready,
	// clock side, read only
	output logic [axi_pkg::ADDR_W-1:0] rtc_araddr,
	output logic rtc_arvalid,
	input  logic rtc_arready,
	input  logic [axi_pkg::DATA_W-1:0] rtc_rdata,
	input  logic [axi_pkg::RESP_W-1:0] rtc_rresp,
	input  logic rtc_rvalid,
	output logic rtc_rready
);

	// read path, one-hot: both low is IDLE
	logic sel_rtc;
	logic sel_sram;
	logic rd_done;
	// write path, high while the SLVERR response is pending
	logic wr_err;
	logic aw_rtc;

	function automatic logic in_rtc(input logic [axi_pkg::ADDR_W-1:0] addr);
		in_rtc = (addr - soc_map_pkg::RTC_BASE) < soc_map_pkg::RTC_SIZE;
	endfunction

	assign rd_done = rvalid && rready && rlast;

	// decode once in idle, then hold until the last beat
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_rtc <= 1'b0;
			sel_sram <= 1'b0;
		end else if (!sel_rtc && !sel_sram) begin
			if (arvalid) begin
				sel_rtc <= in_rtc(araddr);
				sel_sram <= !in_rtc(araddr);
			end
		end else if (rd_done) begin
			sel_rtc <= 1'b0;
			sel_sram <= 1'b0;
		end
	end

	// address payload goes to both sides, valids only to the locked one
	assign sram_araddr = araddr;
	assign sram_arsize = arsize;
	assign sram_arlen = arlen;
	assign sram_arburst = arburst;
	assign rtc_araddr = araddr;

	assign sram_arvalid = sel_sram && arvalid;
	assign rtc_arvalid = sel_rtc && arvalid;
	assign sram_rready = sel_sram && rready;
	assign rtc_rready = sel_rtc && rready;

	always_comb begin
		arready = 1'b0;
		rdata = '0;
		rresp = axi_pkg::RESP_OKAY;
		rvalid = 1'b0;
		rlast = 1'b0;
		if (sel_sram) begin
			arready = sram_arready;
			rdata = sram_rdata;
			rresp = sram_rresp;
			rvalid = sram_rvalid;
			rlast = sram_rlast;
		end else if (sel_rtc) begin
			arready = rtc_arready;
			rdata = rtc_rdata;
			rresp = rtc_rresp;
			rvalid = rtc_rvalid;
			// clock slave answers with a single beat
			rlast = 1'b1;
		end
	end

	// writes to the clock window never reach a slave
	assign aw_rtc = awvalid && in_rtc(awaddr);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_err <= 1'b0;
		end else if (!wr_err && aw_rtc && wvalid) begin
			wr_err <= 1'b1;
		end else if (wr_err && bready) begin
			wr_err <= 1'b0;
		end
	end

	assign sram_awaddr = awaddr;
	assign sram_wdata = wdata;
	assign sram_wstrb = wstrb;

	always_comb begin
		sram_awvalid = 1'b0;
		sram_wvalid = 1'b0;
		sram_bready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = axi_pkg::RESP_OKAY;
		if (wr_err) begin
			bvalid = 1'b1;
			bresp = axi_pkg::RESP_SLVERR;
		end else if (aw_rtc) begin
			// take address and data in the same cycle
			awready = wvalid;
			wready = wvalid;
		end else begin
			sram_awvalid = awvalid;
			sram_wvalid = wvalid;
			sram_bready = bready;
			awready = sram_awready;
			wready = sram_wready;
			bvalid = sram_bvalid;
			bresp = sram_bresp;
		end
	end

	// a slave response seen in idle would be lost
	assert property (@(posedge clk) disable iff (rst)
		(!sel_rtc && !sel_sram) |-> (!sram_rvalid && !rtc_rvalid));

	assert property (@(posedge clk) disable iff (rst)
		!(sram_arvalid && rtc_arvalid));

	assert property (@(posedge clk) disable iff (rst)
		(bvalid && !bready) |=> bvalid);

endmodule

`default_nettype wire

//--- hdl/rtc_slave.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_slave (
	input  logic clk,
	input  logic rst,
	input  logic [axi_pkg::ADDR_W-1:0] rtc_araddr,
	input  logic rtc_arvalid,
	output logic rtc_arready,
	output logic [axi_pkg::DATA_W-1:0] rtc_rdata,
	output logic [axi_pkg::RESP_W-1:0] rtc_rresp,
	output logic rtc_rvalid,
	input  logic rtc_rready
);

	logic [2*axi_pkg::DATA_W-1:0] count;
	logic [axi_pkg::DATA_W-1:0] hi_snap;
	logic [axi_pkg::ADDR_W-1:0] ofs;
	logic ar_hs;

	assign rtc_arready = !rtc_rvalid;
	assign ar_hs = rtc_arvalid && rtc_arready;
	assign ofs = rtc_araddr - soc_map_pkg::RTC_BASE;
	assign rtc_rresp = axi_pkg::RESP_OKAY;

	// free running cycle count
	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rtc_rvalid <= 1'b0;
		end else if (ar_hs) begin
			rtc_rvalid <= 1'b1;
		end else if (rtc_rready) begin
			rtc_rvalid <= 1'b0;
		end
	end

	// low read latches the high half so a later high read is coherent
	always_ff @(posedge clk) begin
		if (rst) begin
			hi_snap <= '0;
		end else if (ar_hs && ofs == soc_map_pkg::RTC_LO_OFS) begin
			hi_snap <= count[2*axi_pkg::DATA_W-1:axi_pkg::DATA_W];
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			case (ofs)
				soc_map_pkg::RTC_LO_OFS: rtc_rdata <= count[axi_pkg::DATA_W-1:0];
				soc_map_pkg::RTC_HI_OFS: rtc_rdata <= hi_snap;
				default: rtc_rdata <= '0;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		(rtc_rvalid && !rtc_rready) |=> (rtc_rvalid && $stable(rtc_rdata)));

endmodule

`default_nettype wire

//--- hdl/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// clock window, two words
	localparam logic [31:0] RTC_BASE = 32'h0200_0000;
	localparam logic [31:0] RTC_SIZE = 32'd8;
	localparam logic [31:0] RTC_LO_OFS = 32'd0;
	localparam logic [31:0] RTC_HI_OFS = 32'd4;

	// memory window, 4 KiB
	localparam logic [31:0] SRAM_BASE = 32'h8000_0000;
	localparam int SRAM_WORDS = 1024;
	localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

endpackage

`default_nettype wire

//--- hdl/soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top (
	input  logic clk,
	input  logic rst,
	input  logic [axi_pkg::ADDR_W-1:0] araddr,
	input  logic arvalid,
	input  logic [axi_pkg::SIZE_W-1:0] arsize,
	input  logic [axi_pkg::LEN_W-1:0] arlen,
	input  logic [axi_pkg::BURST_W-1:0] arburst,
	output logic arready,
	output logic [axi_pkg::DATA_W-1:0] rdata,
	output logic [axi_pkg::RESP_W-1:0] rresp,
	output logic rvalid,
	output logic rlast,
	input  logic rready,
	input  logic [axi_pkg::ADDR_W-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [axi_pkg::DATA_W-1:0] wdata,
	input  logic [axi_pkg::STRB_W-1:0] wstrb,
	input  logic wvalid,
	output logic wready,
	output logic [axi_pkg::RESP_W-1:0] bresp,
	output logic bvalid,
	input  logic bready
);

	// crossbar to sram
	logic [axi_pkg::ADDR_W-1:0] sram_araddr;
	logic sram_arvalid;
	logic [axi_pkg::SIZE_W-1:0] sram_arsize;
	logic [axi_pkg::LEN_W-1:0] sram_arlen;
	logic [axi_pkg::BURST_W-1:0] sram_arburst;
	logic sram_arready;
	logic [axi_pkg::DATA_W-1:0] sram_rdata;
	logic [axi_pkg::RESP_W-1:0] sram_rresp;
	logic sram_rvalid;
	logic sram_rlast;
	logic sram_rready;
	logic [axi_pkg::ADDR_W-1:0] sram_awaddr;
	logic sram_awvalid;
	logic sram_awready;
	logic [axi_pkg::DATA_W-1:0] sram_wdata;
	logic [axi_pkg::STRB_W-1:0] sram_wstrb;
	logic sram_wvalid;
	logic sram_wready;
	logic [axi_pkg::RESP_W-1:0] sram_bresp;
	logic sram_bvalid;
	logic sram_bready;

	// crossbar to clock
	logic [axi_pkg::ADDR_W-1:0] rtc_araddr;
	logic rtc_arvalid;
	logic rtc_arready;
	logic [axi_pkg::DATA_W-1:0] rtc_rdata;
	logic [axi_pkg::RESP_W-1:0] rtc_rresp;
	logic rtc_rvalid;
	logic rtc_rready;

	axi_xbar u_xbar (
		.clk(clk), .rst(rst),
		.araddr(araddr), .arvalid(arvalid), .arsize(arsize), .arlen(arlen),
		.arburst(arburst), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rlast(rlast), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.sram_araddr(sram_araddr), .sram_arvalid(sram_arvalid), .sram_arsize(sram_arsize),
		.sram_arlen(sram_arlen), .sram_arburst(sram_arburst), .sram_arready(sram_arready),
		.sram_rdata(sram_rdata), .sram_rresp(sram_rresp), .sram_rvalid(sram_rvalid),
		.sram_rlast(sram_rlast), .sram_rready(sram_rready),
		.sram_awaddr(sram_awaddr), .sram_awvalid(sram_awvalid), .sram_awready(sram_awready),
		.sram_wdata(sram_wdata), .sram_wstrb(sram_wstrb), .sram_wvalid(sram_wvalid),
		.sram_wready(sram_wready),
		.sram_bresp(sram_bresp), .sram_bvalid(sram_bvalid), .sram_bready(sram_bready),
		.rtc_araddr(rtc_araddr), .rtc_arvalid(rtc_arvalid), .rtc_arready(rtc_arready),
		.rtc_rdata(rtc_rdata), .rtc_rresp(rtc_rresp), .rtc_rvalid(rtc_rvalid),
		.rtc_rready(rtc_rready)
	);

	rtc_slave u_rtc (
		.clk(clk), .rst(rst),
		.rtc_araddr(rtc_araddr), .rtc_arvalid(rtc_arvalid), .rtc_arready(rtc_arready),
		.rtc_rdata(rtc_rdata), .rtc_rresp(rtc_rresp), .rtc_rvalid(rtc_rvalid),
		.rtc_rready(rtc_rready)
	);

	sram_slave u_sram (
		.clk(clk), .rst(rst),
		.sram_araddr(sram_araddr), .sram_arvalid(sram_arvalid), .sram_arsize(sram_arsize),
		.sram_arlen(sram_arlen), .sram_arburst(sram_arburst), .sram_arready(sram_arready),
		.sram_rdata(sram_rdata), .sram_rresp(sram_rresp), .sram_rvalid(sram_rvalid),
		.sram_rlast(sram_rlast), .sram_rready(sram_rready),
		.sram_awaddr(sram_awaddr), .sram_awvalid(sram_awvalid), .sram_awready(sram_awready),
		.sram_wdata(sram_wdata), .sram_wstrb(sram_wstrb), .sram_wvalid(sram_wvalid),
		.sram_wready(sram_wready),
		.sram_bresp(sram_bresp), .sram_bvalid(sram_bvalid), .sram_bready(sram_bready)
	);

endmodule

`default_nettype wire

//--- hdl/sram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module sram_slave (
	input  logic clk,
	input  logic rst,
	input  logic [axi_pkg::ADDR_W-1:0] sram_araddr,
	input  logic sram_arvalid,
	input  logic [axi_pkg::SIZE_W-1:0] sram_arsize,
	input  logic [axi_pkg::LEN_W-1:0] sram_arlen,
	input  logic [axi_pkg::BURST_W-1:0] sram_arburst,
	output logic sram_arready,
	output logic [axi_pkg::DATA_W-1:0] sram_rdata,
	output logic [axi_pkg::RESP_W-1:0] sram_rresp,
	output logic sram_rvalid,
	output logic sram_rlast,
	input  logic sram_rready,
	input  logic [axi_pkg::ADDR_W-1:0] sram_awaddr,
	input  logic sram_awvalid,
	output logic sram_awready,
	input  logic [axi_pkg::DATA_W-1:0] sram_wdata,
	input  logic [axi_pkg::STRB_W-1:0] sram_wstrb,
	input  logic sram_wvalid,
	output logic sram_wready,
	output logic [axi_pkg::RESP_W-1:0] sram_bresp,
	output logic sram_bvalid,
	input  logic sram_bready
);

	logic [axi_pkg::DATA_W-1:0] mem [soc_map_pkg::SRAM_WORDS];

	logic [axi_pkg::ADDR_W-1:0] ar_ofs;
	logic [soc_map_pkg::SRAM_IDX_W-1:0] ar_idx;
	logic [axi_pkg::RESP_W-1:0] ar_resp;
	logic ar_hs;
	logic r_hs;

	// burst engine state
	logic [soc_map_pkg::SRAM_IDX_W-1:0] rd_idx;
	logic [soc_map_pkg::SRAM_IDX_W-1:0] nxt_idx;
	logic [axi_pkg::LEN_W-1:0] rd_len;
	logic [axi_pkg::LEN_W-1:0] beat;
	logic [axi_pkg::BURST_W-1:0] rd_burst;

	logic [axi_pkg::ADDR_W-1:0] aw_ofs;
	logic [soc_map_pkg::SRAM_IDX_W-1:0] aw_idx;
	logic aw_in;
	logic w_hs;

	assign ar_ofs = sram_araddr - soc_map_pkg::SRAM_BASE;
	assign ar_idx = ar_ofs[soc_map_pkg::SRAM_IDX_W+1:2];

	// window first, then burst type and beat size
	always_comb begin
		if (ar_ofs[axi_pkg::ADDR_W-1:soc_map_pkg::SRAM_IDX_W+2] != '0) begin
			ar_resp = axi_pkg::RESP_DECERR;
		end else if (sram_arburst == axi_pkg::BURST_WRAP ||
				sram_arsize > axi_pkg::SIZE_WORD) begin
			ar_resp = axi_pkg::RESP_SLVERR;
		end else begin
			ar_resp = axi_pkg::RESP_OKAY;
		end
	end

	always_comb begin
		case (rd_burst)
			axi_pkg::BURST_INCR: nxt_idx = rd_idx + 1'b1;
			axi_pkg::BURST_FIXED: nxt_idx = rd_idx;
			default: nxt_idx = rd_idx;
		endcase
	end

	assign sram_arready = !sram_rvalid;
	assign ar_hs = sram_arvalid && sram_arready;
	assign r_hs = sram_rvalid && sram_rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			sram_rvalid <= 1'b0;
			sram_rlast <= 1'b0;
			beat <= '0;
		end else if (ar_hs) begin
			sram_rvalid <= 1'b1;
			sram_rlast <= (sram_arlen == '0);
			beat <= '0;
		end else if (r_hs) begin
			if (sram_rlast) begin
				sram_rvalid <= 1'b0;
				sram_rlast <= 1'b0;
			end else begin
				beat <= beat + 1'b1;
				sram_rlast <= (beat + 1'b1 == rd_len);
			end
		end
	end

	// error bursts still run their beats, with zero data
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_idx <= ar_idx;
			rd_len <= sram_arlen;
			rd_burst <= sram_arburst;
			sram_rresp <= ar_resp;
			sram_rdata <= (ar_resp == axi_pkg::RESP_OKAY) ? mem[ar_idx] : '0;
		end else if (r_hs && !sram_rlast) begin
			rd_idx <= nxt_idx;
			sram_rdata <= (sram_rresp == axi_pkg::RESP_OKAY) ? mem[nxt_idx] : '0;
		end
	end

	// single beat write
	assign aw_ofs = sram_awaddr - soc_map_pkg::SRAM_BASE;
	assign aw_idx = aw_ofs[soc_map_pkg::SRAM_IDX_W+1:2];
	assign aw_in = (aw_ofs[axi_pkg::ADDR_W-1:soc_map_pkg::SRAM_IDX_W+2] == '0);
	assign w_hs = sram_awvalid && sram_wvalid && !sram_bvalid;
	assign sram_awready = w_hs;
	assign sram_wready = w_hs;

	always_ff @(posedge clk) begin
		if (rst) begin
			sram_bvalid <= 1'b0;
		end else if (w_hs) begin
			sram_bvalid <= 1'b1;
		end else if (sram_bready) begin
			sram_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (w_hs) begin
			sram_bresp <= aw_in ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
		end
	end

	// byte lanes under strobe
	always_ff @(posedge clk) begin
		if (w_hs && aw_in) begin
			for (int i = 0; i < axi_pkg::STRB_W; i++) begin
				if (sram_wstrb[i]) begin
					mem[aw_idx][8*i +: 8] <= sram_wdata[8*i +: 8];
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		sram_rvalid |-> (sram_rlast == (beat == rd_len)));

endmodule

`default_nettype wire
